/* hdl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  // -------------------------------------------------------------------------
  // Configuration register layout
  // -------------------------------------------------------------------------
  localparam int CFG_DATA_W   = 32;
  localparam int CTRL_EN_BIT  = 0;
  localparam int CTRL_INV_BIT = 1;

  // Access kind issued by the core
  typedef enum logic {
    LSU_OP_LOAD  = 1'b0,
    LSU_OP_STORE = 1'b1
  } lsu_op_e;

  // Access controller states
  typedef enum logic [2:0] {
    PIPE_IDLE       = 3'd0,
    PIPE_LOOKUP     = 3'd1,
    PIPE_CHECK      = 3'd2,
    PIPE_DRAIN_WAIT = 3'd3,
    PIPE_MISS_WAIT  = 3'd4,
    PIPE_STORE_PUSH = 3'd5,
    PIPE_RESP       = 3'd6
  } pipe_state_e;

  // Configuration register addresses
  typedef enum logic [1:0] {
    CFG_CTRL   = 2'd0,
    CFG_HITS   = 2'd1,
    CFG_MISSES = 2'd2
  } cfg_reg_e;

endpackage

`default_nettype wire

/* hdl/l1d_pkg.sv */
`default_nettype none

package l1d_pkg;

  // -------------------------------------------------------------------------
  // L1D geometry
  // -------------------------------------------------------------------------
  localparam int WORD_W    = 32;
  localparam int LINE_W    = 128;
  localparam int L1D_LINES = 16;

  // Address split: tag | index | byte offset
  localparam int OFFSET_W  = 4;
  localparam int INDEX_W   = 4;
  localparam int TAG_W     = 24;
  localparam int ADDR_W    = 32;

endpackage

`default_nettype wire

/* hdl/lsu_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// Lookup port, result one cycle after s0_valid
interface l1d_rd_if
  import l1d_pkg::*;
();
  logic              s0_valid;
  logic [ADDR_W-1:0] s0_addr;
  logic              s1_hit;
  logic [LINE_W-1:0] s1_line;

  modport requester (output s0_valid, s0_addr, input s1_hit, s1_line);
  modport cache     (input s0_valid, s0_addr, output s1_hit, s1_line);
endinterface

// Four-phase L2 request, word writes and line reads
interface l2_req_if
  import l1d_pkg::*;
();
  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [WORD_W-1:0] wdata;
  logic              ack;
  logic [LINE_W-1:0] rdata;

  modport master (output req, we, addr, wdata, input ack, rdata);
  modport slave  (input req, we, addr, wdata, output ack, rdata);
endinterface

`default_nettype wire

/* hdl/lsu_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_csr
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_cfg_we,
  input  cfg_reg_e              i_cfg_addr,
  input  logic [CFG_DATA_W-1:0] i_cfg_wdata,
  output logic [CFG_DATA_W-1:0] o_cfg_rdata,
  input  logic                  i_hit_evt,
  input  logic                  i_miss_evt,
  output logic                  o_cache_en,
  output logic                  o_invalidate
);

  logic                  r_cache_en;
  logic [CFG_DATA_W-1:0] r_hits;
  logic [CFG_DATA_W-1:0] r_misses;
  logic                  w_ctrl_wr;

  assign w_ctrl_wr  = i_cfg_we & (i_cfg_addr == CFG_CTRL);
  assign o_cache_en = r_cache_en;

  // Invalidate acts on the edge that samples the write, never stored
  assign o_invalidate = w_ctrl_wr & i_cfg_wdata[CTRL_INV_BIT];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_cache_en <= 1'b1;
      r_hits     <= '0;
      r_misses   <= '0;
    end else begin
      if (w_ctrl_wr) r_cache_en <= i_cfg_wdata[CTRL_EN_BIT];
      // Saturating event counters
      if (i_hit_evt && (r_hits != '1)) r_hits <= r_hits + 1'b1;
      if (i_miss_evt && (r_misses != '1)) r_misses <= r_misses + 1'b1;
    end
  end

  always_comb begin
    o_cfg_rdata = '0;
    case (i_cfg_addr)
      CFG_CTRL:   o_cfg_rdata[CTRL_EN_BIT] = r_cache_en;
      CFG_HITS:   o_cfg_rdata = r_hits;
      CFG_MISSES: o_cfg_rdata = r_misses;
      default:    o_cfg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/lsu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe
  import lsu_pkg::*;
  import l1d_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_req,
  input  lsu_op_e           i_op,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [WORD_W-1:0] i_wdata,
  output logic              o_ack,
  output logic [WORD_W-1:0] o_rdata,
  l1d_rd_if.requester       rd,
  output logic              o_upd_valid,
  output logic [ADDR_W-1:0] o_upd_addr,
  output logic [WORD_W-1:0] o_upd_word,
  output logic              o_miss_start,
  output logic [ADDR_W-1:0] o_miss_addr,
  input  logic              i_miss_done,
  input  logic [LINE_W-1:0] i_miss_line,
  output logic              o_st_push,
  output logic [ADDR_W-1:0] o_st_addr,
  output logic [WORD_W-1:0] o_st_word,
  input  logic              i_st_full,
  input  logic              i_st_empty,
  output logic              o_hit_evt,
  output logic              o_miss_evt
);

  pipe_state_e         r_state;
  lsu_op_e             r_op;
  logic [ADDR_W-1:0]   r_addr;
  logic [WORD_W-1:0]   r_wdata;
  logic [WORD_W-1:0]   r_rdata;
  logic                w_is_load;
  logic                w_check;
  logic [OFFSET_W-3:0] w_wsel;

  assign w_is_load = (r_op == LSU_OP_LOAD);
  assign w_check   = (r_state == PIPE_CHECK);
  assign w_wsel    = r_addr[OFFSET_W-1:2];

  // Lookup issued in LOOKUP, judged in CHECK
  assign rd.s0_valid = (r_state == PIPE_LOOKUP);
  assign rd.s0_addr  = r_addr;
  assign o_hit_evt   = w_check & w_is_load & rd.s1_hit;
  assign o_miss_evt  = w_check & w_is_load & ~rd.s1_hit;

  // Line fetch only once every earlier store has reached L2
  assign o_miss_start = i_st_empty & (o_miss_evt | (r_state == PIPE_DRAIN_WAIT));
  assign o_miss_addr  = r_addr;

  // Store updates a resident word and posts to the buffer together
  assign o_upd_valid = w_check & ~w_is_load;
  assign o_upd_addr  = r_addr;
  assign o_upd_word  = r_wdata;
  assign o_st_push   = ~w_is_load & ~i_st_full & (w_check | (r_state == PIPE_STORE_PUSH));
  assign o_st_addr   = r_addr;
  assign o_st_word   = r_wdata;

  assign o_ack   = (r_state == PIPE_RESP);
  assign o_rdata = r_rdata;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= PIPE_IDLE;
    end else begin
      case (r_state)
        PIPE_IDLE:   if (i_req) r_state <= PIPE_LOOKUP;
        PIPE_LOOKUP: r_state <= PIPE_CHECK;
        PIPE_CHECK: begin
          if (o_hit_evt || o_st_push) r_state <= PIPE_RESP;
          else if (o_miss_start) r_state <= PIPE_MISS_WAIT;
          else if (o_miss_evt) r_state <= PIPE_DRAIN_WAIT;
          else r_state <= PIPE_STORE_PUSH;
        end
        PIPE_DRAIN_WAIT: if (i_st_empty) r_state <= PIPE_MISS_WAIT;
        PIPE_MISS_WAIT:  if (i_miss_done) r_state <= PIPE_RESP;
        PIPE_STORE_PUSH: if (!i_st_full) r_state <= PIPE_RESP;
        PIPE_RESP:       if (!i_req) r_state <= PIPE_IDLE;
        default:         r_state <= PIPE_IDLE;
      endcase
    end
  end

  // Access payload and load result
  always_ff @(posedge i_clk) begin
    if ((r_state == PIPE_IDLE) && i_req) begin
      r_op    <= i_op;
      r_addr  <= i_addr;
      r_wdata <= i_wdata;
    end
    if (o_hit_evt) r_rdata <= rd.s1_line[w_wsel*WORD_W +: WORD_W];
    if ((r_state == PIPE_MISS_WAIT) && i_miss_done) begin
      r_rdata <= i_miss_line[w_wsel*WORD_W +: WORD_W];
    end
  end

endmodule

`default_nettype wire

/* hdl/l1d_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module l1d_cache
  import l1d_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,
  l1d_rd_if.cache           rd,
  input  logic              i_fill_valid,
  input  logic [ADDR_W-1:0] i_fill_addr,
  input  logic [LINE_W-1:0] i_fill_line,
  input  logic              i_upd_valid,
  input  logic [ADDR_W-1:0] i_upd_addr,
  input  logic [WORD_W-1:0] i_upd_word,
  input  logic              i_cache_en,
  input  logic              i_invalidate
);

  // -------------------------------------------------------------------------
  // Arrays
  // -------------------------------------------------------------------------
  logic [TAG_W-1:0]     r_tag  [L1D_LINES];
  logic [LINE_W-1:0]    r_data [L1D_LINES];
  logic [L1D_LINES-1:0] r_valid;
  logic                 r_s1_hit;
  logic [LINE_W-1:0]    r_s1_line;

  logic [INDEX_W-1:0]   w_rd_idx;
  logic [INDEX_W-1:0]   w_fill_idx;
  logic [INDEX_W-1:0]   w_upd_idx;
  logic [TAG_W-1:0]     w_rd_tag;
  logic [TAG_W-1:0]     w_fill_tag;
  logic [TAG_W-1:0]     w_upd_tag;
  logic [OFFSET_W-3:0]  w_upd_wsel;
  logic                 w_fill_en;
  logic                 w_upd_en;

  assign w_rd_idx   = rd.s0_addr[OFFSET_W +: INDEX_W];
  assign w_rd_tag   = rd.s0_addr[ADDR_W-1 -: TAG_W];
  assign w_fill_idx = i_fill_addr[OFFSET_W +: INDEX_W];
  assign w_fill_tag = i_fill_addr[ADDR_W-1 -: TAG_W];
  assign w_upd_idx  = i_upd_addr[OFFSET_W +: INDEX_W];
  assign w_upd_tag  = i_upd_addr[ADDR_W-1 -: TAG_W];
  assign w_upd_wsel = i_upd_addr[OFFSET_W-1:2];

  // Disabled cache takes no new lines
  assign w_fill_en = i_fill_valid & i_cache_en;
  // Word update only on a resident line with matching tag
  assign w_upd_en  = i_upd_valid & r_valid[w_upd_idx] & (r_tag[w_upd_idx] == w_upd_tag);

  assign rd.s1_hit  = r_s1_hit;
  assign rd.s1_line = r_s1_line;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= '0;
      r_s1_hit <= 1'b0;
    end else begin
      if (i_invalidate) r_valid <= '0;
      else if (w_fill_en) r_valid[w_fill_idx] <= 1'b1;
      r_s1_hit <= rd.s0_valid & i_cache_en & r_valid[w_rd_idx]
                  & (r_tag[w_rd_idx] == w_rd_tag);
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_fill_en) begin
      r_tag[w_fill_idx]  <= w_fill_tag;
      r_data[w_fill_idx] <= i_fill_line;
    end
    if (w_upd_en) r_data[w_upd_idx][w_upd_wsel*WORD_W +: WORD_W] <= i_upd_word;
    if (rd.s0_valid) r_s1_line <= r_data[w_rd_idx];
  end

endmodule

`default_nettype wire

/* hdl/miss_requester.sv */
`timescale 1ns/1ps
`default_nettype none

module miss_requester
  import l1d_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_miss_start,
  input  logic [ADDR_W-1:0] i_miss_addr,
  output logic              o_miss_done,
  output logic [LINE_W-1:0] o_miss_line,
  output logic              o_fill_valid,
  output logic [ADDR_W-1:0] o_fill_addr,
  output logic [LINE_W-1:0] o_fill_line,
  l2_req_if.master          l2
);

  typedef enum logic [1:0] {
    MR_IDLE,
    MR_REQ,
    MR_RELEASE
  } mr_state_e;

  mr_state_e         r_state;
  logic [ADDR_W-1:0] r_line_addr;
  logic [LINE_W-1:0] r_line;
  logic              w_done;

  // Transfer ends when the slave drops ack
  assign w_done = (r_state == MR_RELEASE) & ~l2.ack;

  assign l2.req   = (r_state == MR_REQ);
  assign l2.we    = 1'b0;
  assign l2.addr  = r_line_addr;
  assign l2.wdata = '0;

  assign o_miss_done  = w_done;
  assign o_miss_line  = r_line;
  assign o_fill_valid = w_done;
  assign o_fill_addr  = r_line_addr;
  assign o_fill_line  = r_line;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= MR_IDLE;
    end else begin
      case (r_state)
        MR_IDLE:    if (i_miss_start) r_state <= MR_REQ;
        MR_REQ:     if (l2.ack) r_state <= MR_RELEASE;
        MR_RELEASE: if (!l2.ack) r_state <= MR_IDLE;
        default:    r_state <= MR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((r_state == MR_IDLE) && i_miss_start) begin
      r_line_addr <= {i_miss_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    end
    // Line captured while ack is high
    if ((r_state == MR_REQ) && l2.ack) r_line <= l2.rdata;
  end

endmodule

`default_nettype wire

/* hdl/store_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module store_writer
  import l1d_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_push,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [WORD_W-1:0] i_word,
  output logic              o_full,
  output logic              o_empty,
  l2_req_if.master          l2
);

  typedef enum logic [1:0] {
    SW_IDLE,
    SW_REQ,
    SW_RELEASE
  } sw_state_e;

  sw_state_e         r_state;
  logic [ADDR_W-1:0] r_addr [2];
  logic [WORD_W-1:0] r_word [2];
  logic              r_wr_ptr;
  logic              r_rd_ptr;
  logic [1:0]        r_count;
  logic              w_push;
  logic              w_pop;

  assign w_push  = i_push & ~o_full;
  // Entry leaves only after the write handshake is complete
  assign w_pop   = (r_state == SW_RELEASE) & ~l2.ack;
  assign o_full  = (r_count == 2'd2);
  assign o_empty = (r_count == 2'd0);

  assign l2.req   = (r_state == SW_REQ);
  assign l2.we    = 1'b1;
  assign l2.addr  = r_addr[r_rd_ptr];
  assign l2.wdata = r_word[r_rd_ptr];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state  <= SW_IDLE;
      r_wr_ptr <= 1'b0;
      r_rd_ptr <= 1'b0;
      r_count  <= 2'd0;
    end else begin
      if (w_push) r_wr_ptr <= ~r_wr_ptr;
      if (w_pop) r_rd_ptr <= ~r_rd_ptr;
      r_count <= r_count + {1'b0, w_push} - {1'b0, w_pop};
      case (r_state)
        SW_IDLE:    if (!o_empty) r_state <= SW_REQ;
        SW_REQ:     if (l2.ack) r_state <= SW_RELEASE;
        SW_RELEASE: if (!l2.ack) r_state <= SW_IDLE;
        default:    r_state <= SW_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_addr[r_wr_ptr] <= i_addr;
      r_word[r_wr_ptr] <= i_word;
    end
  end

endmodule

`default_nettype wire

/* hdl/l2_req_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_req_arbiter (
  input  logic     i_clk,
  input  logic     i_reset_n,
  l2_req_if.slave  st_in,
  l2_req_if.slave  ld_in,
  l2_req_if.master l2_out
);

  logic r_busy;
  logic r_grant_st;
  logic w_owner_req;

  assign w_owner_req = r_grant_st ? st_in.req : ld_in.req;

  // Request path follows the registered owner
  assign l2_out.req   = r_busy & w_owner_req;
  assign l2_out.we    = r_grant_st ? st_in.we    : ld_in.we;
  assign l2_out.addr  = r_grant_st ? st_in.addr  : ld_in.addr;
  assign l2_out.wdata = r_grant_st ? st_in.wdata : ld_in.wdata;

  // Response only to the owner
  assign st_in.ack   = r_busy & r_grant_st & l2_out.ack;
  assign ld_in.ack   = r_busy & ~r_grant_st & l2_out.ack;
  assign st_in.rdata = r_grant_st ? l2_out.rdata : '0;
  assign ld_in.rdata = r_grant_st ? '0 : l2_out.rdata;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_busy     <= 1'b0;
      r_grant_st <= 1'b0;
    end else if (!r_busy) begin
      // Stores first
      if (st_in.req || ld_in.req) begin
        r_busy     <= 1'b1;
        r_grant_st <= st_in.req;
      end
    end else if (!w_owner_req && !l2_out.ack) begin
      r_busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hdl/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top
  import lsu_pkg::*;
  import l1d_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  // Core port
  input  logic                  i_req,
  input  lsu_op_e               i_op,
  input  logic [ADDR_W-1:0]     i_addr,
  input  logic [WORD_W-1:0]     i_wdata,
  output logic                  o_ack,
  output logic [WORD_W-1:0]     o_rdata,
  // Configuration port
  input  logic                  i_cfg_we,
  input  cfg_reg_e              i_cfg_addr,
  input  logic [CFG_DATA_W-1:0] i_cfg_wdata,
  output logic [CFG_DATA_W-1:0] o_cfg_rdata,
  // L2 port
  output logic                  o_l2_req,
  output logic                  o_l2_we,
  output logic [ADDR_W-1:0]     o_l2_addr,
  output logic [WORD_W-1:0]     o_l2_wdata,
  input  logic                  i_l2_ack,
  input  logic [LINE_W-1:0]     i_l2_rdata
);

  l1d_rd_if w_rd_if ();
  l2_req_if w_l2_st ();
  l2_req_if w_l2_ld ();
  l2_req_if w_l2_out ();

  logic              w_cache_en;
  logic              w_invalidate;
  logic              w_hit_evt;
  logic              w_miss_evt;
  logic              w_upd_valid;
  logic [ADDR_W-1:0] w_upd_addr;
  logic [WORD_W-1:0] w_upd_word;
  logic              w_miss_start;
  logic [ADDR_W-1:0] w_miss_addr;
  logic              w_miss_done;
  logic [LINE_W-1:0] w_miss_line;
  logic              w_fill_valid;
  logic [ADDR_W-1:0] w_fill_addr;
  logic [LINE_W-1:0] w_fill_line;
  logic              w_st_push;
  logic [ADDR_W-1:0] w_st_addr;
  logic [WORD_W-1:0] w_st_word;
  logic              w_st_full;
  logic              w_st_empty;

  // -------------------------------------------------------------------------
  // External L2 port
  // -------------------------------------------------------------------------
  assign o_l2_req       = w_l2_out.req;
  assign o_l2_we        = w_l2_out.we;
  assign o_l2_addr      = w_l2_out.addr;
  assign o_l2_wdata     = w_l2_out.wdata;
  assign w_l2_out.ack   = i_l2_ack;
  assign w_l2_out.rdata = i_l2_rdata;

  lsu_csr u_csr (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_cfg_we     (i_cfg_we),
    .i_cfg_addr   (i_cfg_addr),
    .i_cfg_wdata  (i_cfg_wdata),
    .o_cfg_rdata  (o_cfg_rdata),
    .i_hit_evt    (w_hit_evt),
    .i_miss_evt   (w_miss_evt),
    .o_cache_en   (w_cache_en),
    .o_invalidate (w_invalidate)
  );

  lsu_pipe u_pipe (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_req        (i_req),
    .i_op         (i_op),
    .i_addr       (i_addr),
    .i_wdata      (i_wdata),
    .o_ack        (o_ack),
    .o_rdata      (o_rdata),
    .rd           (w_rd_if.requester),
    .o_upd_valid  (w_upd_valid),
    .o_upd_addr   (w_upd_addr),
    .o_upd_word   (w_upd_word),
    .o_miss_start (w_miss_start),
    .o_miss_addr  (w_miss_addr),
    .i_miss_done  (w_miss_done),
    .i_miss_line  (w_miss_line),
    .o_st_push    (w_st_push),
    .o_st_addr    (w_st_addr),
    .o_st_word    (w_st_word),
    .i_st_full    (w_st_full),
    .i_st_empty   (w_st_empty),
    .o_hit_evt    (w_hit_evt),
    .o_miss_evt   (w_miss_evt)
  );

  l1d_cache u_cache (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .rd           (w_rd_if.cache),
    .i_fill_valid (w_fill_valid),
    .i_fill_addr  (w_fill_addr),
    .i_fill_line  (w_fill_line),
    .i_upd_valid  (w_upd_valid),
    .i_upd_addr   (w_upd_addr),
    .i_upd_word   (w_upd_word),
    .i_cache_en   (w_cache_en),
    .i_invalidate (w_invalidate)
  );

  miss_requester u_miss (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_miss_start (w_miss_start),
    .i_miss_addr  (w_miss_addr),
    .o_miss_done  (w_miss_done),
    .o_miss_line  (w_miss_line),
    .o_fill_valid (w_fill_valid),
    .o_fill_addr  (w_fill_addr),
    .o_fill_line  (w_fill_line),
    .l2           (w_l2_ld.master)
  );

  store_writer u_store (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_push    (w_st_push),
    .i_addr    (w_st_addr),
    .i_word    (w_st_word),
    .o_full    (w_st_full),
    .o_empty   (w_st_empty),
    .l2        (w_l2_st.master)
  );

  l2_req_arbiter u_arb (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .st_in     (w_l2_st.slave),
    .ld_in     (w_l2_ld.slave),
    .l2_out    (w_l2_out.master)
  );

endmodule

`default_nettype wire

/* bench/lsu_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_assertions
  import lsu_pkg::*;
(
  input  wire         i_clk,
  input  wire         i_reset_n,
  input  wire         i_req,
  input  lsu_op_e     i_op,
  input  wire         i_ack,
  input  wire         i_l2_req,
  input  wire         i_l2_ack,
  input  pipe_state_e i_state,
  input  wire         i_hit_evt
);

  // Count of failed assertions
  int unsigned fail_cnt = 0;

  // -------------------------------------------------------------------------
  // Core handshake
  // -------------------------------------------------------------------------
  a_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $rose(i_ack) |-> $past(i_req))
    else begin
      $error("o_ack rose while i_req was low");
      fail_cnt++;
    end

  a_ack_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ack && i_req |=> i_ack)
    else begin
      $error("o_ack dropped before i_req fell");
      fail_cnt++;
    end

  a_ack_release: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ack && !i_req |=> !i_ack)
    else begin
      $error("o_ack stayed high after i_req fell");
      fail_cnt++;
    end

  // Fixed latency on a hit
  a_hit_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_state == PIPE_IDLE && i_req && i_op == LSU_OP_LOAD) ##2 i_hit_evt
      |-> !i_ack ##1 i_ack)
    else begin
      $error("load hit not acked three cycles after request");
      fail_cnt++;
    end

  // -------------------------------------------------------------------------
  // L2 four-phase port
  // -------------------------------------------------------------------------
  a_l2_req_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_l2_req && !i_l2_ack |=> i_l2_req)
    else begin
      $error("o_l2_req dropped before i_l2_ack");
      fail_cnt++;
    end

  a_l2_req_rise: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $rose(i_l2_req) |-> !$past(i_l2_ack))
    else begin
      $error("o_l2_req rose while i_l2_ack was high");
      fail_cnt++;
    end

endmodule

bind lsu_top lsu_assertions u_asrt (
  .i_clk     (i_clk),
  .i_reset_n (i_reset_n),
  .i_req     (i_req),
  .i_op      (i_op),
  .i_ack     (o_ack),
  .i_l2_req  (o_l2_req),
  .i_l2_ack  (i_l2_ack),
  .i_state   (u_pipe.r_state),
  .i_hit_evt (w_hit_evt)
);

`default_nettype wire

/* bench/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
  import lsu_pkg::*;
  import l1d_pkg::*;
();

  localparam int MEM_WORDS   = 1024;
  localparam int CYCLE_LIMIT = 200 * 40;

  logic                  clk;
  logic                  reset_n;
  logic                  req;
  lsu_op_e               op;
  logic [ADDR_W-1:0]     addr;
  logic [WORD_W-1:0]     wdata;
  logic                  ack;
  logic [WORD_W-1:0]     rdata;
  logic                  cfg_we;
  cfg_reg_e              cfg_addr;
  logic [CFG_DATA_W-1:0] cfg_wdata;
  logic [CFG_DATA_W-1:0] cfg_rdata;
  logic                  l2_req;
  logic                  l2_we;
  logic [ADDR_W-1:0]     l2_addr;
  logic [WORD_W-1:0]     l2_wdata;
  logic                  l2_ack;
  logic [LINE_W-1:0]     l2_rdata;

  // L2 memory, reference copy and shadow tags
  logic [WORD_W-1:0]    l2_mem  [MEM_WORDS];
  logic [WORD_W-1:0]    ref_mem [MEM_WORDS];
  logic [ADDR_W-1:0]    wr_log  [$];
  logic [TAG_W-1:0]     sh_tag  [L1D_LINES];
  logic [L1D_LINES-1:0] sh_valid;
  logic                 cache_en_ref;
  int unsigned          exp_hits;
  int unsigned          exp_misses;
  int unsigned          cycles;
  logic [31:0]          stim_rng;
  logic [31:0]          l2_rng;
  logic                 l2_slow;
  int unsigned          l2_delay;
  logic [ADDR_W-1:0]    a;
  logic [31:0]          v;
  int unsigned          log_base;

  lsu_top dut0 (
    .i_clk(clk), .i_reset_n(reset_n),
    .i_req(req), .i_op(op), .i_addr(addr), .i_wdata(wdata), .o_ack(ack), .o_rdata(rdata),
    .i_cfg_we(cfg_we), .i_cfg_addr(cfg_addr), .i_cfg_wdata(cfg_wdata),
    .o_cfg_rdata(cfg_rdata),
    .o_l2_req(l2_req), .o_l2_we(l2_we), .o_l2_addr(l2_addr), .o_l2_wdata(l2_wdata),
    .i_l2_ack(l2_ack), .i_l2_rdata(l2_rdata)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("[ERROR] %0t %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  // --------------------------------------------------------------------------
  // L2 slave model with an ack delay of 0 to 5 cycles
  // --------------------------------------------------------------------------
  always begin
    @(negedge clk);
    if (l2_req === 1'b1 && !l2_ack) begin
      l2_rng   = lcg_next(l2_rng);
      l2_delay = l2_slow ? 5 : (l2_rng >> 16) % 6;
      repeat (l2_delay) @(negedge clk);
      if (l2_we) begin
        l2_mem[l2_addr[11:2]] = l2_wdata;
        wr_log.push_back(l2_addr);
      end else begin
        for (int j = 0; j < 4; j++) begin
          l2_rdata[j*WORD_W +: WORD_W] = l2_mem[{l2_addr[11:4], 2'b00} + j];
        end
      end
      l2_ack = 1'b1;
      do @(negedge clk); while (l2_req);
      l2_ack = 1'b0;
    end
  end

  // Run limit and protocol watch
  always @(negedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $fatal(1, "Timeout");
    end else if (dut0.u_asrt.fail_cnt != 0) begin
      $display("A protocol assertion failed in lsu_assertions");
      $display(">>> FAIL");
      $fatal(1, "Protocol violation");
    end
  end

  // --------------------------------------------------------------------------
  // Core and configuration transfers
  // --------------------------------------------------------------------------
  task automatic core_access(input lsu_op_e kind, input logic [31:0] ad,
                             input logic [31:0] d, output logic [31:0] r);
    @(negedge clk);
    req   = 1'b1;
    op    = kind;
    addr  = ad;
    wdata = d;
    while (!ack) @(negedge clk);
    r = rdata;
    // Odd words keep req up one more cycle while o_ack is high
    if (ad[2]) @(negedge clk);
    req = 1'b0;
    while (ack) @(negedge clk);
  endtask

  task automatic cfg_write(input cfg_reg_e ra, input logic [31:0] d);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = ra;
    cfg_wdata = d;
    @(negedge clk);
    cfg_we    = 1'b0;
  endtask

  task automatic cfg_read(input cfg_reg_e ra, output logic [31:0] d);
    @(negedge clk);
    cfg_addr = ra;
    @(negedge clk);
    d = cfg_rdata;
  endtask

  task automatic check_counters();
    logic [31:0] h;
    logic [31:0] m;
    cfg_read(CFG_HITS, h);
    cfg_read(CFG_MISSES, m);
    assert (h == exp_hits && m == exp_misses)
      else stop_on_error($sformatf("counters hits=%0d misses=%0d, expected %0d/%0d",
                                   h, m, exp_hits, exp_misses));
  endtask

  task automatic store_word(input logic [31:0] ad, input logic [31:0] d);
    logic [31:0] unused;
    core_access(LSU_OP_STORE, ad, d, unused);
    ref_mem[ad[11:2]] = d;
  endtask

  // Load with the hit rule from the shadow tags
  task automatic check_load(input logic [31:0] ad);
    logic [31:0]        got;
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    logic               hit;
    idx = ad[OFFSET_W +: INDEX_W];
    tag = ad[ADDR_W-1 -: TAG_W];
    hit = cache_en_ref && sh_valid[idx] && (sh_tag[idx] == tag);
    core_access(LSU_OP_LOAD, ad, 32'h0, got);
    assert (got === ref_mem[ad[11:2]])
      else stop_on_error($sformatf("load 0x%08h returned 0x%08h, expected 0x%08h",
                                   ad, got, ref_mem[ad[11:2]]));
    if (hit) begin
      exp_hits++;
    end else begin
      exp_misses++;
      if (cache_en_ref) begin
        sh_valid[idx] = 1'b1;
        sh_tag[idx]   = tag;
      end
    end
    check_counters();
  endtask

  initial begin
    clk          = 1'b0;
    reset_n      = 1'b0;
    req          = 1'b0;
    op           = LSU_OP_LOAD;
    addr         = '0;
    wdata        = '0;
    cfg_we       = 1'b0;
    cfg_addr     = CFG_CTRL;
    cfg_wdata    = '0;
    l2_ack       = 1'b0;
    l2_rdata     = '0;
    stim_rng     = 32'h96fa;
    l2_rng       = 32'h96fa;
    l2_slow      = 1'b0;
    cycles       = 0;
    sh_valid     = '0;
    cache_en_ref = 1'b1;
    exp_hits     = 0;
    exp_misses   = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      l2_mem[i]  = (i << 2) ^ 32'h5a5a_0000;
      ref_mem[i] = l2_mem[i];
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // After reset
    @(negedge clk);
    assert (ack === 1'b0 && l2_req === 1'b0)
      else stop_on_error("o_ack or o_l2_req not low after reset");
    cfg_read(CFG_CTRL, v);
    assert (v == 32'h1) else stop_on_error($sformatf("CFG_CTRL reads 0x%08h", v));
    check_counters();

    // Miss then hit in the same line
    check_load(32'h100);
    check_load(32'h10c);

    // Write-through on a resident and a non-resident line
    store_word(32'h104, 32'hcafe_0104);
    check_load(32'h104);
    store_word(32'h200, 32'hbeef_0200);
    check_load(32'h200);
    assert (l2_mem[32'h200 >> 2] == 32'hbeef_0200)
      else stop_on_error("L2 memory does not hold the stored word");

    // Same index with different tags
    for (int n = 0; n < 4; n++) check_load(n[0] ? 32'h140 : 32'h040);

    // Random loads and stores over 1 KB
    for (int n = 0; n < 60; n++) begin
      stim_rng = lcg_next(stim_rng);
      a = {22'h0, stim_rng[17:10], 2'b00};
      if (stim_rng[24]) begin
        stim_rng = lcg_next(stim_rng);
        store_word(a, stim_rng);
      end else begin
        check_load(a);
      end
    end

    // Cache disabled and then re-enabled with invalidate
    check_load(32'h100);
    cfg_write(CFG_CTRL, 32'h0);
    cache_en_ref = 1'b0;
    check_load(32'h100);
    check_load(32'h104);
    cfg_write(CFG_CTRL, 32'h3);
    cache_en_ref = 1'b1;
    sh_valid = '0;
    cfg_read(CFG_CTRL, v);
    assert (v == 32'h1) else stop_on_error($sformatf("CFG_CTRL reads 0x%08h", v));
    check_load(32'h100);
    check_load(32'h100);

    // Back-to-back stores against a slow L2
    cfg_write(CFG_CTRL, 32'h3);
    sh_valid = '0;
    l2_slow  = 1'b1;
    log_base = wr_log.size();
    store_word(32'h300, 32'h1111_0300);
    store_word(32'h304, 32'h2222_0304);
    store_word(32'h308, 32'h3333_0308);
    check_load(32'h308);
    assert (wr_log.size() == log_base + 3)
      else stop_on_error($sformatf("%0d L2 writes seen, expected 3", wr_log.size() - log_base));
    for (int k = 0; k < 3; k++) begin
      assert (wr_log[log_base + k] == 32'h300 + 4 * k)
        else stop_on_error($sformatf("L2 write %0d went to 0x%08h", k, wr_log[log_base + k]));
    end

    @(negedge clk);
    if (dut0.u_asrt.fail_cnt != 0) begin
      $display("A protocol assertion failed in lsu_assertions");
      $display(">>> FAIL");
      $fatal(1, "Protocol violation");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sources.f */
hdl/lsu_pkg.sv
hdl/l1d_pkg.sv
hdl/lsu_ifs.sv
hdl/lsu_csr.sv
hdl/lsu_pipe.sv
hdl/l1d_cache.sv
hdl/miss_requester.sv
hdl/store_writer.sv
hdl/l2_req_arbiter.sv
hdl/lsu_top.sv
bench/lsu_assertions.sv
bench/lsu_tb.sv
